// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// Sizes of the machine
	localparam int NUM_REGS = 8;
	localparam int MEM_WORDS = 512;
	localparam int WORD_W = 16;
	// The address width follows from the memory size, 9 bits for 512 words
	localparam int ADDR_W = $clog2(MEM_WORDS);
	localparam int REG_IDX_W = $clog2(NUM_REGS);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Instruction bits 15:13
	typedef enum logic [2:0] {
		op_branch = 3'b001,
		op_ldr    = 3'b011,
		op_str    = 3'b100,
		op_alu    = 3'b101,
		op_mov    = 3'b110,
		op_halt   = 3'b111
	} opcode_t;

	// Instruction bits 12:11
	typedef enum logic [1:0] {
		alu_add = 2'b00,
		alu_cmp = 2'b01,
		alu_and = 2'b10,
		alu_mvn = 2'b11
	} alu_op_t;

	// Instruction bits 4:3, a one-bit shift of the second operand
	typedef enum logic [1:0] {
		sh_none = 2'b00,
		sh_lsl  = 2'b01,
		sh_lsr  = 2'b10,
		sh_asr  = 2'b11
	} shift_t;

	// Branch condition in instruction bits 10:8
	typedef enum logic [2:0] {
		cond_al = 3'b000,
		cond_eq = 3'b001,
		cond_ne = 3'b010,
		cond_lt = 3'b011,
		cond_le = 3'b100
	} cond_t;

	typedef enum logic [1:0] {
		sel_rn = 2'b00,
		sel_rd = 2'b01,
		sel_rm = 2'b10
	} reg_sel_t;

	typedef enum logic [1:0] {
		wb_mdata = 2'b00,
		wb_imm8  = 2'b01,
		wb_c     = 2'b11
	} wb_sel_t;

	typedef enum logic [1:0] {
		mem_none  = 2'b00,
		mem_read  = 2'b01,
		mem_write = 2'b10
	} mem_cmd_t;

	typedef enum logic [3:0] {
		st_reset      = 4'd0,
		st_clear_pc   = 4'd1,
		st_fetch      = 4'd2,
		st_decode     = 4'd3,
		st_get_a      = 4'd4,
		st_get_b      = 4'd5,
		st_execute    = 4'd6,
		st_address    = 4'd7,
		st_memory     = 4'd8,
		st_write_back = 4'd9,
		st_write_imm  = 4'd10,
		st_halt       = 4'd11
	} state_t;

	// For a MOV the op field picks the form, and 2'b10 marks the immediate form
	localparam alu_op_t MOV_IMM_OP = alu_and;

endpackage

`default_nettype wire

// ==== alu_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_shifter (
	input wire cpu_pkg::word_t a,
	input wire cpu_pkg::word_t b,
	input wire cpu_pkg::shift_t shift,
	input wire cpu_pkg::alu_op_t op,
	output cpu_pkg::word_t result,
	output logic n,
	output logic v,
	output logic z
);

	localparam int MSB = cpu_pkg::WORD_W - 1;

	cpu_pkg::word_t bs;
	cpu_pkg::word_t sum;
	cpu_pkg::word_t diff;
	logic v_add;
	logic v_sub;

	// One-bit shift of the second operand, ASR keeps the sign bit
	always_comb begin
		case (shift)
			cpu_pkg::sh_lsl: bs = {b[MSB-1:0], 1'b0};
			cpu_pkg::sh_lsr: bs = {1'b0, b[MSB:1]};
			cpu_pkg::sh_asr: bs = {b[MSB], b[MSB:1]};
			default: bs = b;
		endcase
	end

	assign sum = a + bs;
	assign diff = a - bs;
	// Overflow when the signs of the operands rule out the sign of the result
	assign v_add = (a[MSB] == bs[MSB]) && (sum[MSB] != a[MSB]);
	assign v_sub = (a[MSB] != bs[MSB]) && (diff[MSB] != a[MSB]);

	always_comb begin
		case (op)
			cpu_pkg::alu_add: begin
				result = sum;
				v = v_add;
			end
			cpu_pkg::alu_cmp: begin
				result = diff;
				v = v_sub;
			end
			cpu_pkg::alu_and: begin
				result = a & bs;
				v = 1'b0;
			end
			default: begin
				result = ~bs;
				v = 1'b0;
			end
		endcase
	end

	assign n = result[MSB];
	assign z = (result == '0);

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic write,
	input wire cpu_pkg::reg_idx_t idx,
	input wire cpu_pkg::word_t wdata,
	output cpu_pkg::word_t rdata
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	// All registers start at zero so programs see known contents
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[idx] <= wdata;
		end
	end

	// Read and write share the index, reads see the value before the edge
	assign rdata = regs[idx];

endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic write,
	input wire logic load_a,
	input wire logic load_b,
	input wire logic load_c,
	input wire logic asel,
	input wire logic bsel,
	input wire logic load_status,
	input wire cpu_pkg::wb_sel_t wb_sel,
	input wire cpu_pkg::reg_idx_t reg_idx,
	input wire cpu_pkg::shift_t shift,
	input wire cpu_pkg::alu_op_t op,
	input wire cpu_pkg::word_t sximm5,
	input wire cpu_pkg::word_t sximm8,
	input wire cpu_pkg::word_t mem_rdata,
	output cpu_pkg::word_t c,
	output logic flag_n,
	output logic flag_v,
	output logic flag_z
);

	cpu_pkg::word_t wdata;
	cpu_pkg::word_t rdata;
	cpu_pkg::word_t a;
	cpu_pkg::word_t b;
	cpu_pkg::word_t a_in;
	cpu_pkg::word_t b_in;
	cpu_pkg::word_t alu_out;
	logic alu_n;
	logic alu_v;
	logic alu_z;

	// Write-back source for the register file
	always_comb begin
		case (wb_sel)
			cpu_pkg::wb_mdata: wdata = mem_rdata;
			cpu_pkg::wb_imm8: wdata = sximm8;
			default: wdata = c;
		endcase
	end

	reg_file u_reg_file (
		.clk(clk),
		.rst_n(rst_n),
		.write(write),
		.idx(reg_idx),
		.wdata(wdata),
		.rdata(rdata)
	);

	// Operand registers take the register file output one at a time
	always_ff @(posedge clk) begin
		if (load_a) begin
			a <= rdata;
		end
		if (load_b) begin
			b <= rdata;
		end
		if (load_c) begin
			c <= alu_out;
		end
	end

	// Zero for A turns the ALU into a pass of B, the offset replaces B for addresses
	assign a_in = asel ? '0 : a;
	assign b_in = bsel ? sximm5 : b;

	alu_shifter u_alu (
		.a(a_in),
		.b(b_in),
		.shift(shift),
		.op(op),
		.result(alu_out),
		.n(alu_n),
		.v(alu_v),
		.z(alu_z)
	);

	// Flags hold between ALU instructions so a later branch can test them
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flag_n <= 1'b0;
			flag_v <= 1'b0;
			flag_z <= 1'b0;
		end else if (load_status) begin
			flag_n <= alu_n;
			flag_v <= alu_v;
			flag_z <= alu_z;
		end
	end

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc_unit (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic load_pc,
	input wire logic reset_pc,
	input wire logic load_addr,
	input wire logic addr_sel,
	input wire cpu_pkg::opcode_t opcode,
	input wire cpu_pkg::cond_t cond,
	input wire cpu_pkg::word_t sximm8,
	input wire logic flag_n,
	input wire logic flag_v,
	input wire logic flag_z,
	input wire cpu_pkg::word_t c,
	output cpu_pkg::addr_t mem_addr
);

	cpu_pkg::addr_t pc;
	cpu_pkg::addr_t pc_inc;
	cpu_pkg::addr_t target;
	cpu_pkg::addr_t data_addr;
	logic cond_met;
	logic take_branch;

	// The PC still holds the address of the current instruction during decode
	assign pc_inc = pc + 1'b1;
	// Only the low address bits of the offset matter, the sum wraps in 512 words
	assign target = pc_inc + sximm8[cpu_pkg::ADDR_W-1:0];

	// Signed compare results come from N and V, equality from Z
	always_comb begin
		case (cond)
			cpu_pkg::cond_al: cond_met = 1'b1;
			cpu_pkg::cond_eq: cond_met = flag_z;
			cpu_pkg::cond_ne: cond_met = !flag_z;
			cpu_pkg::cond_lt: cond_met = (flag_n != flag_v);
			cpu_pkg::cond_le: cond_met = (flag_n != flag_v) || flag_z;
			default: cond_met = 1'b0;
		endcase
	end

	// The condition field only means something for the branch opcode
	assign take_branch = (opcode == cpu_pkg::op_branch) && cond_met;

	always_ff @(posedge clk) begin
		if (!rst_n || reset_pc) begin
			pc <= '0;
		end else if (load_pc) begin
			pc <= take_branch ? target : pc_inc;
		end
	end

	// Holds the load or store address while C is reused for store data
	always_ff @(posedge clk) begin
		if (load_addr) begin
			data_addr <= c[cpu_pkg::ADDR_W-1:0];
		end
	end

	// Fetches use the PC, loads and stores use the data address
	assign mem_addr = addr_sel ? pc : data_addr;

endmodule

`default_nettype wire

// ==== instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic load_ir,
	input wire cpu_pkg::word_t mem_rdata,
	input wire cpu_pkg::reg_sel_t reg_sel,
	output cpu_pkg::opcode_t opcode,
	output cpu_pkg::alu_op_t op,
	output cpu_pkg::cond_t cond,
	output cpu_pkg::shift_t shift,
	output cpu_pkg::word_t sximm5,
	output cpu_pkg::word_t sximm8,
	output cpu_pkg::reg_idx_t reg_idx
);

	cpu_pkg::word_t ir;
	cpu_pkg::reg_idx_t rn;
	cpu_pkg::reg_idx_t rd;
	cpu_pkg::reg_idx_t rm;
	logic is_mem;

	// The instruction register captures the word read during fetch
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ir <= '0;
		end else if (load_ir) begin
			ir <= mem_rdata;
		end
	end

	assign opcode = cpu_pkg::opcode_t'(ir[15:13]);
	assign is_mem = (opcode == cpu_pkg::op_ldr) || (opcode == cpu_pkg::op_str);

	// Address computation is always an unshifted add of base and offset
	assign op = is_mem ? cpu_pkg::alu_add : cpu_pkg::alu_op_t'(ir[12:11]);
	assign shift = is_mem ? cpu_pkg::sh_none : cpu_pkg::shift_t'(ir[4:3]);
	// Branches reuse the Rn bits as the condition
	assign cond = cpu_pkg::cond_t'(ir[10:8]);

	assign sximm5 = {{11{ir[4]}}, ir[4:0]};
	assign sximm8 = {{8{ir[7]}}, ir[7:0]};

	assign rn = ir[10:8];
	assign rd = ir[7:5];
	assign rm = ir[2:0];

	// One index serves the read port and the write port of the register file
	always_comb begin
		case (reg_sel)
			cpu_pkg::sel_rn: reg_idx = rn;
			cpu_pkg::sel_rd: reg_idx = rd;
			default: reg_idx = rm;
		endcase
	end

endmodule

`default_nettype wire

// ==== control_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_fsm (
	input wire logic clk,
	input wire logic rst_n,
	input wire cpu_pkg::opcode_t opcode,
	input wire cpu_pkg::alu_op_t op,
	output logic load_ir,
	output logic load_pc,
	output logic reset_pc,
	output logic load_addr,
	output logic addr_sel,
	output cpu_pkg::reg_sel_t reg_sel,
	output cpu_pkg::wb_sel_t wb_sel,
	output logic write,
	output logic load_a,
	output logic load_b,
	output logic load_c,
	output logic asel,
	output logic bsel,
	output logic load_status,
	output cpu_pkg::mem_cmd_t mem_cmd,
	output logic halted
);

	cpu_pkg::state_t state;
	cpu_pkg::state_t next_state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cpu_pkg::st_reset;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			cpu_pkg::st_reset: next_state = cpu_pkg::st_clear_pc;
			cpu_pkg::st_clear_pc: next_state = cpu_pkg::st_fetch;
			cpu_pkg::st_fetch: next_state = cpu_pkg::st_decode;
			cpu_pkg::st_decode: begin
				case (opcode)
					cpu_pkg::op_mov: begin
						if (op == cpu_pkg::MOV_IMM_OP) begin
							next_state = cpu_pkg::st_write_imm;
						end else begin
							next_state = cpu_pkg::st_get_b;
						end
					end
					// MVN has no first operand, so it skips reading A
					cpu_pkg::op_alu: begin
						if (op == cpu_pkg::alu_mvn) begin
							next_state = cpu_pkg::st_get_b;
						end else begin
							next_state = cpu_pkg::st_get_a;
						end
					end
					cpu_pkg::op_ldr: next_state = cpu_pkg::st_get_a;
					cpu_pkg::op_str: next_state = cpu_pkg::st_get_a;
					// Branches spend an idle execute cycle after the PC update
					cpu_pkg::op_branch: next_state = cpu_pkg::st_execute;
					cpu_pkg::op_halt: next_state = cpu_pkg::st_halt;
					default: next_state = cpu_pkg::st_fetch;
				endcase
			end
			// A load needs no second register, a store reads Rd as its data
			cpu_pkg::st_get_a: begin
				if (opcode == cpu_pkg::op_ldr) begin
					next_state = cpu_pkg::st_execute;
				end else begin
					next_state = cpu_pkg::st_get_b;
				end
			end
			cpu_pkg::st_get_b: next_state = cpu_pkg::st_execute;
			cpu_pkg::st_execute: begin
				case (opcode)
					cpu_pkg::op_alu: begin
						// CMP only updates the flags and writes no register
						if (op == cpu_pkg::alu_cmp) begin
							next_state = cpu_pkg::st_fetch;
						end else begin
							next_state = cpu_pkg::st_write_back;
						end
					end
					cpu_pkg::op_mov: next_state = cpu_pkg::st_write_back;
					cpu_pkg::op_ldr: next_state = cpu_pkg::st_address;
					cpu_pkg::op_str: next_state = cpu_pkg::st_address;
					default: next_state = cpu_pkg::st_fetch;
				endcase
			end
			cpu_pkg::st_address: next_state = cpu_pkg::st_memory;
			cpu_pkg::st_memory: next_state = cpu_pkg::st_fetch;
			cpu_pkg::st_write_back: next_state = cpu_pkg::st_fetch;
			cpu_pkg::st_write_imm: next_state = cpu_pkg::st_fetch;
			// Only reset leaves the halt state
			cpu_pkg::st_halt: next_state = cpu_pkg::st_halt;
			default: next_state = cpu_pkg::st_reset;
		endcase
	end

	// Every output idles unless the current state asks for it
	always_comb begin
		load_ir = 1'b0;
		load_pc = 1'b0;
		reset_pc = 1'b0;
		load_addr = 1'b0;
		addr_sel = 1'b0;
		reg_sel = cpu_pkg::sel_rn;
		wb_sel = cpu_pkg::wb_c;
		write = 1'b0;
		load_a = 1'b0;
		load_b = 1'b0;
		load_c = 1'b0;
		asel = 1'b0;
		bsel = 1'b0;
		load_status = 1'b0;
		mem_cmd = cpu_pkg::mem_none;
		halted = 1'b0;
		case (state)
			cpu_pkg::st_clear_pc: reset_pc = 1'b1;
			cpu_pkg::st_fetch: begin
				addr_sel = 1'b1;
				mem_cmd = cpu_pkg::mem_read;
				load_ir = 1'b1;
			end
			// The only PC update of each instruction, taken or not
			cpu_pkg::st_decode: load_pc = 1'b1;
			cpu_pkg::st_get_a: begin
				reg_sel = cpu_pkg::sel_rn;
				load_a = 1'b1;
			end
			cpu_pkg::st_get_b: begin
				reg_sel = (opcode == cpu_pkg::op_str) ? cpu_pkg::sel_rd : cpu_pkg::sel_rm;
				load_b = 1'b1;
			end
			cpu_pkg::st_execute: begin
				case (opcode)
					cpu_pkg::op_alu: begin
						load_c = 1'b1;
						load_status = 1'b1;
					end
					// A shifted MOV is zero plus the shifted register
					cpu_pkg::op_mov: begin
						asel = 1'b1;
						load_c = 1'b1;
					end
					// Base plus offset, with the offset taking the place of B
					cpu_pkg::op_ldr, cpu_pkg::op_str: begin
						bsel = 1'b1;
						load_c = 1'b1;
					end
					default: load_c = 1'b0;
				endcase
			end
			cpu_pkg::st_address: begin
				load_addr = 1'b1;
				// A store moves Rd from B into C at the same edge as the address capture
				if (opcode == cpu_pkg::op_str) begin
					asel = 1'b1;
					load_c = 1'b1;
				end
			end
			cpu_pkg::st_memory: begin
				if (opcode == cpu_pkg::op_ldr) begin
					mem_cmd = cpu_pkg::mem_read;
					reg_sel = cpu_pkg::sel_rd;
					wb_sel = cpu_pkg::wb_mdata;
					write = 1'b1;
				end else begin
					mem_cmd = cpu_pkg::mem_write;
				end
			end
			cpu_pkg::st_write_back: begin
				reg_sel = cpu_pkg::sel_rd;
				wb_sel = cpu_pkg::wb_c;
				write = 1'b1;
			end
			cpu_pkg::st_write_imm: begin
				reg_sel = cpu_pkg::sel_rn;
				wb_sel = cpu_pkg::wb_imm8;
				write = 1'b1;
			end
			cpu_pkg::st_halt: halted = 1'b1;
			default: halted = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input wire logic clk,
	input wire logic rst_n,
	input wire cpu_pkg::word_t mem_rdata,
	output cpu_pkg::addr_t mem_addr,
	output cpu_pkg::mem_cmd_t mem_cmd,
	output cpu_pkg::word_t mem_wdata,
	output logic flag_n,
	output logic flag_v,
	output logic flag_z,
	output logic halted
);

	// Decoded instruction fields
	cpu_pkg::opcode_t opcode;
	cpu_pkg::alu_op_t op;
	cpu_pkg::cond_t cond;
	cpu_pkg::shift_t shift;
	cpu_pkg::word_t sximm5;
	cpu_pkg::word_t sximm8;
	cpu_pkg::reg_idx_t reg_idx;

	// Control levels from the FSM
	logic load_ir;
	logic load_pc;
	logic reset_pc;
	logic load_addr;
	logic addr_sel;
	logic write;
	logic load_a;
	logic load_b;
	logic load_c;
	logic asel;
	logic bsel;
	logic load_status;
	cpu_pkg::reg_sel_t reg_sel;
	cpu_pkg::wb_sel_t wb_sel;

	instr_decoder u_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.load_ir(load_ir),
		.mem_rdata(mem_rdata),
		.reg_sel(reg_sel),
		.opcode(opcode),
		.op(op),
		.cond(cond),
		.shift(shift),
		.sximm5(sximm5),
		.sximm8(sximm8),
		.reg_idx(reg_idx)
	);

	control_fsm u_control (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.op(op),
		.load_ir(load_ir),
		.load_pc(load_pc),
		.reset_pc(reset_pc),
		.load_addr(load_addr),
		.addr_sel(addr_sel),
		.reg_sel(reg_sel),
		.wb_sel(wb_sel),
		.write(write),
		.load_a(load_a),
		.load_b(load_b),
		.load_c(load_c),
		.asel(asel),
		.bsel(bsel),
		.load_status(load_status),
		.mem_cmd(mem_cmd),
		.halted(halted)
	);

	// The branch test reads the same flags that leave on the top-level ports
	pc_unit u_pc (
		.clk(clk),
		.rst_n(rst_n),
		.load_pc(load_pc),
		.reset_pc(reset_pc),
		.load_addr(load_addr),
		.addr_sel(addr_sel),
		.opcode(opcode),
		.cond(cond),
		.sximm8(sximm8),
		.flag_n(flag_n),
		.flag_v(flag_v),
		.flag_z(flag_z),
		.c(mem_wdata),
		.mem_addr(mem_addr)
	);

	// Register C serves as store data and as the source of the data address
	datapath u_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.write(write),
		.load_a(load_a),
		.load_b(load_b),
		.load_c(load_c),
		.asel(asel),
		.bsel(bsel),
		.load_status(load_status),
		.wb_sel(wb_sel),
		.reg_idx(reg_idx),
		.shift(shift),
		.op(op),
		.sximm5(sximm5),
		.sximm8(sximm8),
		.mem_rdata(mem_rdata),
		.c(mem_wdata),
		.flag_n(flag_n),
		.flag_v(flag_v),
		.flag_z(flag_z)
	);

endmodule

`default_nettype wire

// ==== tb_programs.svh ====
// Test programs with their preloaded data word and the results they must leave
// Each close_entry gives the data word, the last store address and value, then N, V and Z
task automatic fill_table();
	// MOV of a positive and a negative immediate, STR with a positive offset
	add_word(mov_imm(3'd1, 8'h40));
	add_word(mov_imm(3'd2, 8'hFA));
	add_word(store_instr(3'd2, 3'd1, 5'd5));
	add_word(halt_instr());
	// Base 0x40 plus 5, and 0xFA sign-extends to 0xFFFA
	close_entry(16'hA5A5, 9'h045, 16'hFFFA, 1'b0, 1'b0, 1'b0);

	// STR with a negative offset, 5'h1D is -3
	add_word(mov_imm(3'd3, 8'h50));
	add_word(mov_imm(3'd4, 8'h7F));
	add_word(store_instr(3'd4, 3'd3, 5'h1D));
	add_word(halt_instr());
	close_entry(16'h5A5A, 9'h04D, 16'h007F, 1'b0, 1'b0, 1'b0);

	// ADD with LSL gives 0x30 + (0x21 * 2) = 0x72
	add_word(mov_imm(3'd1, 8'h30));
	add_word(mov_imm(3'd2, 8'h21));
	add_word(alu_instr(cpu_pkg::alu_add, 3'd3, 3'd1, 3'd2, cpu_pkg::sh_lsl));
	add_word(mov_imm(3'd5, 8'h60));
	add_word(store_instr(3'd3, 3'd5, 5'd6));
	add_word(halt_instr());
	close_entry(16'h0000, 9'h066, 16'h0072, 1'b0, 1'b0, 1'b0);

	// AND of 0x005C and 0xFFC6 keeps bits 6 and 2
	add_word(mov_imm(3'd1, 8'h5C));
	add_word(mov_imm(3'd2, 8'hC6));
	add_word(alu_instr(cpu_pkg::alu_and, 3'd3, 3'd1, 3'd2, cpu_pkg::sh_none));
	add_word(mov_imm(3'd5, 8'h60));
	add_word(store_instr(3'd3, 3'd5, 5'd5));
	add_word(halt_instr());
	close_entry(16'h0000, 9'h065, 16'h0044, 1'b0, 1'b0, 1'b0);

	// MVN with ASR, 0xFFE0 shifts to 0xFFF0 and inverts to 0x000F
	add_word(mov_imm(3'd2, 8'hE0));
	add_word(alu_instr(cpu_pkg::alu_mvn, 3'd3, 3'd0, 3'd2, cpu_pkg::sh_asr));
	add_word(mov_imm(3'd5, 8'h60));
	add_word(store_instr(3'd3, 3'd5, 5'd4));
	add_word(halt_instr());
	close_entry(16'h0000, 9'h064, 16'h000F, 1'b0, 1'b0, 1'b0);

	// MOV with LSR moves a zero into the sign bit, 0xFFFE becomes 0x7FFF
	add_word(mov_imm(3'd1, 8'hFE));
	add_word(mov_imm(3'd5, 8'h60));
	add_word(mov_reg(3'd4, 3'd1, cpu_pkg::sh_lsr));
	add_word(store_instr(3'd4, 3'd5, 5'd1));
	add_word(halt_instr());
	close_entry(16'h0000, 9'h061, 16'h7FFF, 1'b0, 1'b0, 1'b0);

	// LDR from 0x6E + 2, then 0x7FF0 + 0x11 overflows into the sign bit
	add_word(mov_imm(3'd1, 8'h6E));
	add_word(load_instr(3'd2, 3'd1, 5'd2));
	add_word(mov_imm(3'd3, 8'h11));
	add_word(alu_instr(cpu_pkg::alu_add, 3'd4, 3'd2, 3'd3, cpu_pkg::sh_none));
	add_word(mov_imm(3'd5, 8'h60));
	add_word(store_instr(3'd4, 3'd5, 5'd2));
	add_word(halt_instr());
	close_entry(16'h7FF0, 9'h062, 16'h8001, 1'b1, 1'b1, 1'b0);

	// CMP of equal operands sets only Z
	add_word(mov_imm(3'd1, 8'h25));
	add_word(mov_imm(3'd2, 8'h25));
	add_word(mov_imm(3'd5, 8'h60));
	add_word(store_instr(3'd1, 3'd5, 5'd7));
	add_word(alu_instr(cpu_pkg::alu_cmp, 3'd0, 3'd1, 3'd2, cpu_pkg::sh_none));
	add_word(halt_instr());
	close_entry(16'h0000, 9'h067, 16'h0025, 1'b0, 1'b0, 1'b1);

	// CMP of 5 against 9 leaves a negative difference without overflow
	add_word(mov_imm(3'd1, 8'h05));
	add_word(mov_imm(3'd2, 8'h09));
	add_word(mov_imm(3'd5, 8'h60));
	add_word(store_instr(3'd2, 3'd5, 5'd8));
	add_word(alu_instr(cpu_pkg::alu_cmp, 3'd0, 3'd1, 3'd2, cpu_pkg::sh_none));
	add_word(halt_instr());
	close_entry(16'h0000, 9'h068, 16'h0009, 1'b1, 1'b0, 1'b0);

	// 0x7FF0 minus -128 does not fit, the difference 0x8070 looks negative
	add_word(mov_imm(3'd1, 8'h70));
	add_word(load_instr(3'd2, 3'd1, 5'd0));
	add_word(mov_imm(3'd3, 8'h80));
	add_word(store_instr(3'd3, 3'd1, 5'd1));
	add_word(alu_instr(cpu_pkg::alu_cmp, 3'd0, 3'd2, 3'd3, cpu_pkg::sh_none));
	add_word(halt_instr());
	close_entry(16'h7FF0, 9'h071, 16'hFF80, 1'b1, 1'b1, 1'b0);

	// Branches after CMP a, b, with the marker that the condition selects
	add_branch_test(cpu_pkg::cond_al, 8'h01, 8'h02, TAKEN_MARK, 1'b1, 1'b0, 1'b0);
	add_branch_test(cpu_pkg::cond_eq, 8'h07, 8'h07, TAKEN_MARK, 1'b0, 1'b0, 1'b1);
	add_branch_test(cpu_pkg::cond_eq, 8'h07, 8'h03, UNTAKEN_MARK, 1'b0, 1'b0, 1'b0);
	add_branch_test(cpu_pkg::cond_ne, 8'h07, 8'h03, TAKEN_MARK, 1'b0, 1'b0, 1'b0);
	add_branch_test(cpu_pkg::cond_ne, 8'h07, 8'h07, UNTAKEN_MARK, 1'b0, 1'b0, 1'b1);
	// -2 is less than 1
	add_branch_test(cpu_pkg::cond_lt, 8'hFE, 8'h01, TAKEN_MARK, 1'b1, 1'b0, 1'b0);
	add_branch_test(cpu_pkg::cond_lt, 8'h07, 8'h03, UNTAKEN_MARK, 1'b0, 1'b0, 1'b0);
	add_branch_test(cpu_pkg::cond_le, 8'h07, 8'h07, TAKEN_MARK, 1'b0, 1'b0, 1'b1);
	add_branch_test(cpu_pkg::cond_le, 8'h03, 8'h07, TAKEN_MARK, 1'b1, 1'b0, 1'b0);
	add_branch_test(cpu_pkg::cond_le, 8'h07, 8'h03, UNTAKEN_MARK, 1'b0, 1'b0, 1'b0);
endtask

// ==== tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

	localparam int MAX_TESTS = 24;
	localparam int PROG_WORDS = 12;
	localparam int RESET_CYCLES = 10;
	localparam int HALT_TIMEOUT = 500;
	localparam cpu_pkg::addr_t DATA_ADDR = 9'h070;
	localparam cpu_pkg::addr_t MARK_ADDR = 9'h060;
	localparam cpu_pkg::word_t UNTAKEN_MARK = 16'h0011;
	localparam cpu_pkg::word_t TAKEN_MARK = 16'h0022;

	logic clk;
	logic rst_n;
	cpu_pkg::word_t mem_rdata;
	cpu_pkg::addr_t mem_addr;
	cpu_pkg::mem_cmd_t mem_cmd;
	cpu_pkg::word_t mem_wdata;
	logic flag_n;
	logic flag_v;
	logic flag_z;
	logic halted;

	// Memory contents and the image that replaces them before each program
	cpu_pkg::word_t mem [cpu_pkg::MEM_WORDS];
	cpu_pkg::word_t image [cpu_pkg::MEM_WORDS];
	logic load_mem;
	cpu_pkg::addr_t last_st_addr;
	cpu_pkg::word_t last_st_data;
	int store_count;
	cpu_pkg::addr_t first_rd_addr;
	logic seen_read;

	// Stimulus table with one row per program
	cpu_pkg::word_t prog_tbl [MAX_TESTS][PROG_WORDS];
	cpu_pkg::word_t data_tbl [MAX_TESTS];
	cpu_pkg::addr_t st_addr_tbl [MAX_TESTS];
	cpu_pkg::word_t st_data_tbl [MAX_TESTS];
	logic n_tbl [MAX_TESTS];
	logic v_tbl [MAX_TESTS];
	logic z_tbl [MAX_TESTS];
	int num_tests;
	int fill_pos;

	int errors;
	int checks;
	int runs;
	logic timed_out;

	cpu_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr),
		.mem_cmd(mem_cmd),
		.mem_wdata(mem_wdata),
		.flag_n(flag_n),
		.flag_v(flag_v),
		.flag_z(flag_z),
		.halted(halted)
	);

	always #5 clk = ~clk;

	// Reads answer at once and writes land at the clock edge
	assign mem_rdata = (mem_cmd == cpu_pkg::mem_read) ? mem[mem_addr] : '0;

	always @(posedge clk) begin
		if (load_mem) begin
			for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
				mem[i] <= image[i];
			end
			store_count <= 0;
			seen_read <= 1'b0;
		end else begin
			if (mem_cmd == cpu_pkg::mem_write) begin
				mem[mem_addr] <= mem_wdata;
				last_st_addr <= mem_addr;
				last_st_data <= mem_wdata;
				store_count <= store_count + 1;
			end
			// The first read after reset must be the fetch from address 0
			if (mem_cmd == cpu_pkg::mem_read && !seen_read) begin
				first_rd_addr <= mem_addr;
				seen_read <= 1'b1;
			end
		end
	end

	// Instruction encodings with the opcode in bits 15:13
	function automatic cpu_pkg::word_t mov_imm(cpu_pkg::reg_idx_t rn, logic [7:0] imm8);
		return {cpu_pkg::op_mov, cpu_pkg::MOV_IMM_OP, rn, imm8};
	endfunction

	function automatic cpu_pkg::word_t mov_reg(cpu_pkg::reg_idx_t rd, cpu_pkg::reg_idx_t rm,
			cpu_pkg::shift_t sh);
		return {cpu_pkg::op_mov, cpu_pkg::alu_add, 3'd0, rd, sh, rm};
	endfunction

	function automatic cpu_pkg::word_t alu_instr(cpu_pkg::alu_op_t op, cpu_pkg::reg_idx_t rd,
			cpu_pkg::reg_idx_t rn, cpu_pkg::reg_idx_t rm, cpu_pkg::shift_t sh);
		return {cpu_pkg::op_alu, op, rn, rd, sh, rm};
	endfunction

	function automatic cpu_pkg::word_t load_instr(cpu_pkg::reg_idx_t rd, cpu_pkg::reg_idx_t rn,
			logic [4:0] imm5);
		return {cpu_pkg::op_ldr, 2'b00, rn, rd, imm5};
	endfunction

	function automatic cpu_pkg::word_t store_instr(cpu_pkg::reg_idx_t rd, cpu_pkg::reg_idx_t rn,
			logic [4:0] imm5);
		return {cpu_pkg::op_str, 2'b00, rn, rd, imm5};
	endfunction

	function automatic cpu_pkg::word_t branch_instr(cpu_pkg::cond_t cond, logic [7:0] imm8);
		return {cpu_pkg::op_branch, 2'b00, cond, imm8};
	endfunction

	function automatic cpu_pkg::word_t halt_instr();
		return {cpu_pkg::op_halt, 13'd0};
	endfunction

	task automatic add_word(cpu_pkg::word_t w);
		if (fill_pos < PROG_WORDS && num_tests < MAX_TESTS) begin
			prog_tbl[num_tests][fill_pos] = w;
			fill_pos++;
		end else begin
			$display("Table entry %0d does not fit in the stimulus table", num_tests);
			errors++;
		end
	endtask

	// Pads the program with HALT and stores the expected results of the row
	task automatic close_entry(cpu_pkg::word_t data, cpu_pkg::addr_t st_addr,
			cpu_pkg::word_t st_data, logic n, logic v, logic z);
		if (num_tests < MAX_TESTS) begin
			for (int i = fill_pos; i < PROG_WORDS; i++) begin
				prog_tbl[num_tests][i] = halt_instr();
			end
			data_tbl[num_tests] = data;
			st_addr_tbl[num_tests] = st_addr;
			st_data_tbl[num_tests] = st_data;
			n_tbl[num_tests] = n;
			v_tbl[num_tests] = v;
			z_tbl[num_tests] = z;
			num_tests++;
		end
		fill_pos = 0;
	endtask

	// The branch at address 4 jumps to 8, so the two paths store different markers
	task automatic add_branch_test(cpu_pkg::cond_t cond, logic [7:0] a, logic [7:0] b,
			cpu_pkg::word_t marker, logic n, logic v, logic z);
		add_word(mov_imm(3'd1, a));
		add_word(mov_imm(3'd2, b));
		add_word(alu_instr(cpu_pkg::alu_cmp, 3'd0, 3'd1, 3'd2, cpu_pkg::sh_none));
		add_word(mov_imm(3'd5, 8'h60));
		add_word(branch_instr(cond, 8'd3));
		add_word(mov_imm(3'd3, UNTAKEN_MARK[7:0]));
		add_word(store_instr(3'd3, 3'd5, 5'd0));
		add_word(halt_instr());
		add_word(mov_imm(3'd3, TAKEN_MARK[7:0]));
		add_word(store_instr(3'd3, 3'd5, 5'd0));
		add_word(halt_instr());
		close_entry(16'h0000, MARK_ADDR, marker, n, v, z);
	endtask

	`include "tb_programs.svh"

	task automatic check_word(string what, cpu_pkg::word_t got, cpu_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(string what, cpu_pkg::addr_t got, cpu_pkg::addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(string what, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_cmd(string what, cpu_pkg::mem_cmd_t got, cpu_pkg::mem_cmd_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Resets the DUT around a fresh memory image, runs to HALT and checks the row
	task automatic run_program(int t);
		int cycles;
		@(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
			image[i] = cpu_pkg::word_t'($urandom);
		end
		for (int i = 0; i < PROG_WORDS; i++) begin
			image[i] = prog_tbl[t][i];
		end
		image[DATA_ADDR] = data_tbl[t];
		load_mem <= 1'b1;
		@(posedge clk);
		load_mem <= 1'b0;
		repeat (RESET_CYCLES - 2) @(posedge clk);
		// Outputs must be idle while the FSM sits in reset
		@(negedge clk);
		check_flag($sformatf("program %0d halted in reset", t), halted, 1'b0);
		check_cmd($sformatf("program %0d mem_cmd in reset", t), mem_cmd, cpu_pkg::mem_none);
		@(posedge clk);
		rst_n <= 1'b1;
		runs++;

		cycles = 0;
		while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("Program %0d did not halt within %0d cycles", t, HALT_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end else begin
			if (!seen_read) begin
				$display("Program %0d halted without any memory read", t);
				errors++;
			end else begin
				check_addr($sformatf("program %0d first read", t), first_rd_addr, 9'h000);
			end
			if (store_count == 0) begin
				$display("Program %0d halted without storing a result", t);
				errors++;
			end else begin
				check_addr($sformatf("program %0d store address", t), last_st_addr,
					st_addr_tbl[t]);
				check_word($sformatf("program %0d store data", t), last_st_data,
					st_data_tbl[t]);
			end
			check_cmd($sformatf("program %0d mem_cmd in halt", t), mem_cmd, cpu_pkg::mem_none);
			check_flag($sformatf("program %0d flag N", t), flag_n, n_tbl[t]);
			check_flag($sformatf("program %0d flag V", t), flag_v, v_tbl[t]);
			check_flag($sformatf("program %0d flag Z", t), flag_z, z_tbl[t]);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		load_mem = 1'b0;
		errors = 0;
		checks = 0;
		runs = 0;
		num_tests = 0;
		fill_pos = 0;
		timed_out = 1'b0;
		void'($urandom(32'h8345));

		fill_table();
		// A timeout leaves the DUT in an unknown state, so the remaining rows are skipped
		for (int t = 0; t < num_tests && !timed_out; t++) begin
			run_program(t);
		end

		$display("Programs run: %0d, checks: %0d, errors: %0d", runs, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
cpu_pkg.sv
alu_shifter.sv
reg_file.sv
datapath.sv
pc_unit.sv
instr_decoder.sv
control_fsm.sv
cpu_top.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cpu -f all.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	exit 1
fi
if ! grep -q "NO ERRORS" "$LOG"; then
	echo "Simulation log has no final result"
	exit 1
fi
exit 0
